// File: sources.f
verilog/uartPkg.sv
verilog/baudGen.sv
verilog/uartFifo.sv
verilog/uartTrans.sv
verilog/uartRecv.sv
verilog/uartPeripheral.sv
testbench/uartAssertions.sv
testbench/uartPeripheralTb.sv

// File: Makefile
# Verilator build and run of the serial port peripheral testbench
# variables can be overridden on the command line

VERILATOR ?= verilator
TOP ?= uartPeripheralTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUNFLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/uartPeripheralTb.sv
// testbench for the serial port peripheral
// loopback of tx into rx, or rx driven directly for frame injection
// immediate assertions check values, the bound module checks the rules
// one line per test, counts and the result at the end

`timescale 1ns/1ns

module uartPeripheralTb;

	logic clk = 1'b0;
	logic reset;
	logic wrStrobe;
	uartPkg::byteT wrData;
	logic rdStrobe;
	uartPkg::byteT rdData;
	logic txFull;
	logic rxEmpty;
	logic rxFull;
	logic txBusy;
	logic tx;
	logic rxLine;	// what the DUT sees on rx
	logic rxDrive;	// testbench level in injection mode
	logic injectMode;	// low means loopback
	logic [31:0] lcgState = 32'd96341;
	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testErrStart = 0;
	uartPkg::byteT sent [0:17];	// bytes in write order

	assign rxLine = injectMode ? rxDrive : tx;

	always #5 clk = ~clk;	// 10 ns period

	uartPeripheral UUT
	(
		.clk(clk),
		.reset(reset),
		.wrStrobe(wrStrobe),
		.wrData(wrData),
		.rdStrobe(rdStrobe),
		.rdData(rdData),
		.txFull(txFull),
		.rxEmpty(rxEmpty),
		.rxFull(rxFull),
		.txBusy(txBusy),
		.tx(tx),
		.rx(rxLine)
	);

	bind uartPeripheral uartAssertions assertChk
	(
		.clk(clk),
		.reset(reset),
		.wrStrobe(wrStrobe),
		.txFull(txFull),
		.rxEmpty(rxEmpty),
		.rxFull(rxFull),
		.txBusy(txBusy),
		.tx(tx),
		.rdData(rdData)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic uartPkg::byteT nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;	// lcg step
		return lcgState[23:16];
	endfunction

	task automatic checkByte(input string sigName, input uartPkg::byteT got,
		input uartPkg::byteT expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			$display("Fail %s: got %h, expected %h", sigName, got, expected);
			errCount++;
		end
	endtask

	task automatic checkBit(input string sigName, input logic got, input logic expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			$display("Fail %s: got %h, expected %h", sigName, got, expected);
			errCount++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout while waiting for %s", what);
		errCount++;
	endtask

	task automatic writeByte(input uartPkg::byteT value);
		wrStrobe = 1'b1;
		wrData = value;
		@(negedge clk);
		wrStrobe = 1'b0;
	endtask

	// waits for a byte, checks the head, then pops it
	task automatic readByte(input uartPkg::byteT expected);
		int n;
		n = 0;
		while (rxEmpty && n < 2000)
		begin
			@(negedge clk);
			n++;
		end
		if (rxEmpty)
			reportTimeout("a received byte");
		checkByte("rdData", rdData, expected);
		rdStrobe = 1'b1;
		@(negedge clk);
		rdStrobe = 1'b0;
	endtask

	// two idle samples in a row, a gap between frames is only one
	task automatic waitTxIdle();
		int n;
		int idleRun;
		n = 0;
		idleRun = 0;
		while (idleRun < 2 && n < 2000)
		begin
			idleRun = txBusy ? 0 : idleRun + 1;
			@(negedge clk);
			n++;
		end
		if (idleRun < 2)
			reportTimeout("the transmitter to go idle");
	endtask

	task automatic waitTxFall();
		int n;
		n = 0;
		while (tx && n < 100)
		begin
			@(negedge clk);
			n++;
		end
		if (tx)
			reportTimeout("the tx start bit");
	endtask

	task automatic waitRxFull();
		int n;
		n = 0;
		while (!rxFull && n < 15000)
		begin
			@(negedge clk);
			n++;
		end
		if (!rxFull)
			reportTimeout("rxFull");
	endtask

	// one frame on rx at 64 clocks per bit
	task automatic sendFrame(input uartPkg::byteT value, input logic stopLevel);
		int i;
		rxDrive = 1'b0;	// start
		repeat (64) @(negedge clk);
		for (i = 0; i < 8; i++)
		begin
			rxDrive = value[i];
			repeat (64) @(negedge clk);
		end
		rxDrive = stopLevel;
		repeat (64) @(negedge clk);
		rxDrive = 1'b1;
	endtask

	task automatic endTest(input int num, input string title);
		testCount++;
		$display("test %0d %s: %0d errors", num, title, errCount - testErrStart);
		testErrStart = errCount;
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial
	begin
		int i;
		int totalErr;
		uartPkg::byteT value;
		reset = 1'b1;
		wrStrobe = 1'b0;
		wrData = '0;
		rdStrobe = 1'b0;
		rxDrive = 1'b1;
		injectMode = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// reset levels
		checkBit("tx", tx, 1'b1);
		checkBit("txBusy", txBusy, 1'b0);
		checkBit("rxEmpty", rxEmpty, 1'b1);
		checkBit("txFull", txFull, 1'b0);
		checkBit("rxFull", rxFull, 1'b0);
		endTest(1, "reset state");

		value = nextRand();
		writeByte(value);
		readByte(value);
		waitTxIdle();
		checkBit("rxEmpty", rxEmpty, 1'b1);
		endTest(2, "single byte loopback");

		// first word leaves the queue at once, so the queue fills on write 17
		waitTxIdle();
		for (i = 0; i < 18; i++)
		begin
			sent[i] = nextRand();
			wrStrobe = 1'b1;
			wrData = sent[i];
			@(negedge clk);
			checkBit("txFull", txFull, i >= 16);
		end
		wrStrobe = 1'b0;
		for (i = 0; i < 17; i++)
			readByte(sent[i]);	// read as each arrives
		waitTxIdle();
		checkBit("rxEmpty", rxEmpty, 1'b1);	// write 18 never sent
		endTest(3, "transmit queue full, extra write dropped");

		// receiver left unread, 17th frame lost
		waitTxIdle();
		for (i = 0; i < 17; i++)
		begin
			sent[i] = nextRand();
			writeByte(sent[i]);
		end
		waitRxFull();
		waitTxIdle();
		checkBit("rxFull", rxFull, 1'b1);
		for (i = 0; i < 16; i++)
			readByte(sent[i]);
		checkBit("rxEmpty", rxEmpty, 1'b1);
		rdStrobe = 1'b1;	// pop from an empty queue is ignored
		@(negedge clk);
		rdStrobe = 1'b0;
		checkBit("rxEmpty", rxEmpty, 1'b1);
		endTest(4, "receive queue full, extra byte dropped");

		waitTxIdle();
		injectMode = 1'b1;
		sendFrame(nextRand(), 1'b0);	// low stop bit
		repeat (128) @(negedge clk);
		checkBit("rxEmpty", rxEmpty, 1'b1);
		value = nextRand();
		sendFrame(value, 1'b1);
		readByte(value);
		checkBit("rxEmpty", rxEmpty, 1'b1);
		rxDrive = 1'b0;	// two tick glitch
		repeat (8) @(negedge clk);
		rxDrive = 1'b1;
		repeat (640) @(negedge clk);
		checkBit("rxEmpty", rxEmpty, 1'b1);
		injectMode = 1'b0;
		endTest(5, "frame injection, bad stop and glitch");

		// tx line sampled mid bit
		value = nextRand();
		writeByte(value);
		waitTxFall();
		repeat (32) @(negedge clk);
		checkBit("tx start bit", tx, 1'b0);
		for (i = 0; i < 8; i++)
		begin
			repeat (64) @(negedge clk);
			checkBit("tx data bit", tx, value[i]);
		end
		repeat (64) @(negedge clk);
		checkBit("tx stop bit", tx, 1'b1);
		readByte(value);
		waitTxIdle();
		endTest(6, "tx line frame timing");

		totalErr = errCount + UUT.assertChk.failCount;
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, totalErr);
		if (totalErr == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: testbench/uartAssertions.sv
// concurrent checks on the status levels and the tx line of the peripheral
// bound to every uartPeripheral instance from the testbench
// failCount is read by the testbench at the end of the run

`timescale 1ns/1ns

module uartAssertions
(
	input logic clk,
	input logic reset,
	input logic wrStrobe,
	input logic txFull,
	input logic rxEmpty,
	input logic rxFull,
	input logic txBusy,
	input logic tx,
	input uartPkg::byteT rdData
);

	int failCount = 0;	// number of failed assertions

	// line idles high whenever the transmitter is idle
	txIdleHigh: assert property (@(posedge clk) disable iff (reset) !txBusy |-> tx)
	else
	begin
		$error("tx line low while the transmitter is idle");
		failCount++;
	end

	// receive queue cannot be empty and full at once
	rxLevels: assert property (@(posedge clk) disable iff (reset) !(rxEmpty && rxFull))
	else
	begin
		$error("rxEmpty and rxFull high together");
		failCount++;
	end

	// write into a full transmit queue is dropped, queue stays full
	txFullHold: assert property (@(posedge clk) disable iff (reset)
		wrStrobe && txFull |=> txFull)
	else
	begin
		$error("txFull fell after a write into a full transmit queue");
		failCount++;
	end

	// head of an empty receive queue never moves
	rdDataHold: assert property (@(posedge clk) disable iff (reset)
		rxEmpty && $past(rxEmpty) |-> rdData === $past(rdData))
	else
	begin
		$error("rdData changed while the receive queue was empty");
		failCount++;
	end

endmodule

// File: verilog/uartPeripheral.sv
// serial port peripheral for the 8-bit processor
// wrStrobe queues wrData for sending, rdStrobe pops the rdData byte
// status levels come straight from the queues and the transmitter
// tx and rx are the serial lines, 8N1

`timescale 1ns/1ns

module uartPeripheral
(
	input logic clk,
	input logic reset,
	input logic wrStrobe,
	input uartPkg::byteT wrData,
	input logic rdStrobe,
	output uartPkg::byteT rdData,
	output logic txFull,
	output logic rxEmpty,
	output logic rxFull,
	output logic txBusy,
	output logic tx,
	input logic rx
);

	logic sTick;	// oversampling tick to both engines
	logic txEmpty;
	logic txStart;	// queue has a word waiting
	logic txDoneTick;	// transmitter took the head word
	uartPkg::byteT txHead;
	uartPkg::byteT rxByte;
	logic rxDoneTick;

	assign txStart = ~txEmpty;

	baudGen baudGen
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	////////////////////////////////////////
	// transmit path
	////////////////////////////////////////

	uartFifo txFifo
	(
		.clk(clk),
		.reset(reset),
		.push(wrStrobe),	// dropped inside when full
		.pushData(wrData),
		.pop(txDoneTick),
		.popData(txHead),
		.full(txFull),
		.empty(txEmpty)
	);

	uartTrans uartTrans
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txStart(txStart),
		.din(txHead),
		.txDoneTick(txDoneTick),
		.tx(tx),
		.txBusy(txBusy)
	);

	////////////////////////////////////////
	// receive path
	////////////////////////////////////////

	uartRecv uartRecv
	(
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxByte(rxByte),
		.rxDoneTick(rxDoneTick)
	);

	uartFifo rxFifo
	(
		.clk(clk),
		.reset(reset),
		.push(rxDoneTick),	// byte lost if queue full
		.pushData(rxByte),
		.pop(rdStrobe),
		.popData(rdData),
		.full(rxFull),
		.empty(rxEmpty)
	);

endmodule

// File: verilog/uartRecv.sv
// serial receiver, 8N1, lsb first, 16x oversampling
// a falling edge on rx starts a frame, the start bit is confirmed near
// mid-bit and the data bits are sampled 16 ticks apart from there
// rxDoneTick pulses one cycle with rxByte valid
// frames with a low stop sample are dropped without a pulse

`timescale 1ns/1ns

module uartRecv
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output uartPkg::byteT rxByte,
	output logic rxDoneTick
);

	logic rxMeta;	// first synchronizer stage
	logic rxSync;	// second stage, safe to use
	logic rxLast;	// previous synchronized level, for edge detect
	uartPkg::serialStateT state;
	uartPkg::tickCntT tickCnt;
	uartPkg::bitCntT bitCnt;
	uartPkg::byteT shiftReg;	// assembled from the top
	logic sampleEn;	// mid-bit of a data bit

	assign sampleEn = (state == uartPkg::data) && sTick &&
		(tickCnt == uartPkg::tickCntT'(uartPkg::overSample - 1));
	assign rxByte = shiftReg;

	////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;	// idle line level
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	////////////////////////////////////////
	// control FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= uartPkg::idle;
			tickCnt <= '0;
			bitCnt <= '0;
			rxDoneTick <= 1'b0;
		end
		else
		begin
			rxDoneTick <= 1'b0;	// single cycle pulse
			case (state)
				uartPkg::idle:
				begin
					if (rxLast && !rxSync)	// falling edge
					begin
						tickCnt <= '0;
						state <= uartPkg::start;
					end
				end
				uartPkg::start:
				begin
					if (sTick && (tickCnt == 4'd7))	// about mid start bit
					begin
						tickCnt <= '0;
						bitCnt <= '0;
						if (rxSync)
							state <= uartPkg::idle;	// glitch, not a start bit
						else
							state <= uartPkg::data;
					end
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				uartPkg::data:
				begin
					if (sampleEn)
					begin
						tickCnt <= '0;
						if (bitCnt == uartPkg::bitCntT'(uartPkg::dataBits - 1))
							state <= uartPkg::stop;
						else
							bitCnt <= bitCnt + 1'b1;
					end
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				uartPkg::stop:
				begin
					if (sTick && (tickCnt == uartPkg::tickCntT'(uartPkg::stopTicks - 1)))
					begin
						rxDoneTick <= rxSync;	// bad stop bit, no pulse
						state <= uartPkg::idle;
					end
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				default: state <= uartPkg::idle;
			endcase
		end
	end

	// data bits enter at the msb, so the first bit ends at the lsb
	always_ff @(posedge clk)
	begin
		if (sampleEn)
			shiftReg <= {rxSync, shiftReg[uartPkg::dataBits-1:1]};
	end

endmodule

// File: verilog/uartTrans.sv
// serial transmitter, 8N1, lsb first
// accepts the queue head while idle and txStart is high
// txDoneTick is the queue pop, din is captured on the same edge
// every bit lasts overSample ticks of sTick

`timescale 1ns/1ns

module uartTrans
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txStart,
	input uartPkg::byteT din,
	output logic txDoneTick,
	output logic tx,
	output logic txBusy
);

	uartPkg::serialStateT state;
	uartPkg::tickCntT tickCnt;	// ticks within current bit
	uartPkg::bitCntT bitCnt;	// data bit index
	uartPkg::byteT shiftReg;	// word being sent, lsb out first
	logic txReg;	// registered line level
	logic bitEnd;	// last tick of a start or data bit
	logic lastBit;
	logic shiftEn;

	assign txDoneTick = (state == uartPkg::idle) && txStart;	// accept and pop
	assign txBusy = (state != uartPkg::idle);
	assign tx = txReg;

	assign bitEnd = sTick && (tickCnt == uartPkg::tickCntT'(uartPkg::overSample - 1));
	assign lastBit = (bitCnt == uartPkg::bitCntT'(uartPkg::dataBits - 1));
	assign shiftEn = (state == uartPkg::data) && bitEnd && !lastBit;

	////////////////////////////////////////
	// control FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= uartPkg::idle;
			tickCnt <= '0;
			bitCnt <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			case (state)
				uartPkg::idle:
				begin
					txReg <= 1'b1;
					if (txStart)
					begin
						tickCnt <= '0;
						txReg <= 1'b0;	// start bit goes out on this same edge
						state <= uartPkg::start;
					end
				end
				uartPkg::start:
				begin
					if (bitEnd)
					begin
						tickCnt <= '0;
						bitCnt <= '0;
						txReg <= shiftReg[0];	// first data bit
						state <= uartPkg::data;
					end
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				uartPkg::data:
				begin
					if (bitEnd)
					begin
						tickCnt <= '0;
						if (lastBit)
						begin
							txReg <= 1'b1;	// stop bit
							state <= uartPkg::stop;
						end
						else
						begin
							bitCnt <= bitCnt + 1'b1;
							txReg <= shiftReg[1];	// next bit, before shift lands
						end
					end
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				uartPkg::stop:
				begin
					if (sTick && (tickCnt == uartPkg::tickCntT'(uartPkg::stopTicks - 1)))
						state <= uartPkg::idle;	// one clock gap before next start
					else if (sTick)
						tickCnt <= tickCnt + 1'b1;
				end
				default: state <= uartPkg::idle;
			endcase
		end
	end

	// data word, loaded on accept and shifted right after each data bit
	always_ff @(posedge clk)
	begin
		if (txDoneTick)
			shiftReg <= din;
		else if (shiftEn)
			shiftReg <= shiftReg >> 1;
	end

endmodule

// File: verilog/uartFifo.sv
// byte queue between the processor strobes and a serial engine
// push while full and pop while empty are ignored
// popData shows the head entry without waiting for a pop
// used once for transmit and once for receive

`timescale 1ns/1ns

module uartFifo
(
	input logic clk,
	input logic reset,
	input logic push,
	input uartPkg::byteT pushData,
	input logic pop,
	output uartPkg::byteT popData,
	output logic full,
	output logic empty
);

	uartPkg::byteT mem [2**uartPkg::fifoAddrLen];	// storage, no reset
	logic [uartPkg::fifoAddrLen-1:0] wrPtr;
	logic [uartPkg::fifoAddrLen-1:0] rdPtr;
	logic [uartPkg::fifoAddrLen:0] count;	// one bit wider than pointers
	logic doPush;
	logic doPop;

	assign doPush = push && !full;	// drop when full
	assign doPop = pop && !empty;	// nothing to pop when empty

	// count of exactly 2**fifoAddrLen means full
	assign full = (count == {1'b1, {uartPkg::fifoAddrLen{1'b0}}});
	assign empty = (count == '0);
	assign popData = mem[rdPtr];	// head entry

	// pointers and occupancy
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none, or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

// File: verilog/baudGen.sv
// oversampling tick generator
// divides clk by clksPerTick and gives a one cycle sTick per period
// single timing source for both transmitter and receiver

`timescale 1ns/1ns

module baudGen
(
	input logic clk,
	input logic reset,
	output logic sTick
);

	uartPkg::divCntT divCnt;	// free running, never realigned

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			if (divCnt == uartPkg::divCntT'(uartPkg::clksPerTick - 1))
			begin
				divCnt <= '0;	// wrap
				sTick <= 1'b1;
			end
			else
			begin
				divCnt <= divCnt + 1'b1;
				sTick <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/uartPkg.sv
// shared constants and types for the serial port peripheral
// holds frame format, oversampling, baud divisor and queue depth
// every other file refers to these by scoped name, uartPkg::name
// compile this file first

package uartPkg;

	////////////////////////////////////////
	// frame format
	////////////////////////////////////////

	localparam int dataBits = 8;	// data bits per frame, lsb first
	localparam int overSample = 16;	// ticks per bit
	localparam int stopTicks = 16;	// one stop bit

	////////////////////////////////////////
	// baud divisor
	////////////////////////////////////////

	// kept small so a frame is only 640 clocks in simulation
	localparam int clksPerTick = 4;
	localparam int divCntLen = $clog2(clksPerTick);	// divider counter width

	// queue depth is 2**fifoAddrLen
	localparam int fifoAddrLen = 4;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	typedef logic [dataBits-1:0] byteT;	// one data byte
	typedef logic [3:0] tickCntT;	// counts ticks within a bit
	typedef logic [2:0] bitCntT;	// counts data bits
	typedef logic [divCntLen-1:0] divCntT;	// baud divider count

	// shared by transmitter and receiver
	typedef enum logic [1:0]
	{
		idle,
		start,
		data,
		stop
	} serialStateT;

endpackage
